//--- source/lagPkg.sv
package lagPkg;

	//////////////////////////////////////////////////
	// Pitch lag limits for 8 kHz speech
	//////////////////////////////////////////////////

	// Smallest lag searched
	localparam logic [15:0] pitMin = 16'd20;
	// Largest lag searched
	localparam logic [15:0] pitMax = 16'd143;

	// Arithmetic unit opcode
	typedef enum logic
	{
		opAdd = 1'b0,
		opSub = 1'b1
	} lagOp_t;

	// Encoder sequence, one arithmetic step per state
	typedef enum logic [4:0]
	{
		idle        = 5'd0,
		latchInputs = 5'd1,
		testLow     = 5'd2,
		tripleLag   = 5'd3,
		offsetLow   = 5'd4,
		indexLow    = 5'd5,
		indexHigh   = 5'd6,
		windowLow   = 5'd7,
		clampMin    = 5'd8,
		windowHigh  = 5'd9,
		clampMax    = 5'd10,
		shiftMin    = 5'd11,
		finish      = 5'd12,
		relLag      = 5'd13,
		relDouble   = 5'd14,
		relTriple   = 5'd15,
		relOffset   = 5'd16,
		relIndex    = 5'd17
	} lagState_t;

endpackage

//--- source/saturatingAddSub.sv
`timescale 1ns/100ps

module saturatingAddSub import lagPkg::*;
(
	input  logic [15:0] a,
	input  logic [15:0] b,
	input  lagOp_t      op,
	output logic [15:0] result
);

	//////////////////////////////////////////////////
	// Signed add or subtract with clamping
	//////////////////////////////////////////////////

	// One guard bit above the 16-bit result
	logic [16:0] wideSum;
	// Guard and sign disagree on overflow
	logic        overflow;

	always_comb
	begin
		if (op == opSub)
			wideSum = {a[15], a} - {b[15], b};
		else
			wideSum = {a[15], a} + {b[15], b};
	end

	assign overflow = wideSum[16] ^ wideSum[15];

	always_comb
	begin
		if (!overflow)
			result = wideSum[15:0];
		else if (wideSum[16])
			// Below -32768
			result = 16'h8000;
		else
			// Above 32767
			result = 16'h7fff;
	end

endmodule

//--- source/lagFrameControl.sv
`timescale 1ns/100ps

module lagFrameControl
(
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic        done,
	input  logic [15:0] t0Min,
	output logic        encStart,
	output logic        pitFlag,
	output logic [15:0] prevT0Min
);

	//////////////////////////////////////////////////
	// Run tracking
	//////////////////////////////////////////////////

	// High from accepted start until done
	logic busy;

	// Start passes through only when no run is open
	assign encStart = start && !busy;

	always_ff @(posedge clk)
	begin
		if (reset)
			busy <= 1'b0;
		else if (done)
			busy <= 1'b0;
		else if (encStart)
			busy <= 1'b1;
	end

	//////////////////////////////////////////////////
	// Subframe tracking
	//////////////////////////////////////////////////

	// 0 for first subframe, 1 for second
	always_ff @(posedge clk)
	begin
		if (reset)
			pitFlag <= 1'b0;
		else if (done)
			pitFlag <= !pitFlag;
	end

	// Window base from first subframe
	// Second subframe index is relative to it
	always_ff @(posedge clk)
	begin
		if (reset)
			prevT0Min <= 16'd0;
		else if (done && !pitFlag)
			prevT0Min <= t0Min;
	end

endmodule

//--- source/lagEncoder.sv
`timescale 1ns/100ps

module lagEncoder import lagPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic        pitFlag,
	input  logic [15:0] t0,
	input  logic [15:0] t0Frac,
	input  logic [15:0] prevT0Min,
	input  logic [15:0] opResult,
	output logic [15:0] opA,
	output logic [15:0] opB,
	output lagOp_t      op,
	output logic [15:0] index,
	output logic [15:0] t0Min,
	output logic [15:0] t0Max,
	output logic        done
);

	// Split between fractional and integer lag coding
	localparam logic [15:0] lagSplit = 16'd85;
	// Offset of low-range index
	localparam logic [15:0] lowOffset = 16'd58;
	// Offset of high-range index
	localparam logic [15:0] highOffset = 16'd112;
	// Window start below lag
	localparam logic [15:0] windowBack = 16'd5;
	// Window width
	localparam logic [15:0] windowSpan = 16'd9;
	// Bias of relative index
	localparam logic [15:0] relBias = 16'd2;

	lagState_t state;
	lagState_t nextState;

	// Latched inputs
	logic [15:0] t0Reg;
	logic [15:0] t0FracReg;
	logic        pitFlagReg;

	// Partial results
	logic [15:0] lagAcc;
	logic [15:0] temp;
	// Second half of lag tripling
	logic        tripleStep;

	// Sign tests on the arithmetic result
	logic resultNonPositive;
	logic resultNegative;

	assign resultNegative = opResult[15];
	assign resultNonPositive = opResult[15] || (opResult == 16'd0);

	assign done = (state == finish);

	//////////////////////////////////////////////////
	// Operand selection and sequencing
	//////////////////////////////////////////////////
	always_comb
	begin
		opA = 16'd0;
		opB = 16'd0;
		op = opAdd;
		nextState = state;
		case (state)
			idle:
			begin
				if (start)
					nextState = latchInputs;
			end
			// Pick subframe path
			latchInputs:
				nextState = pitFlagReg ? relLag : testLow;
			testLow:
			begin
				opA = t0Reg;
				opB = lagSplit;
				op = opSub;
				nextState = resultNonPositive ? tripleLag : indexHigh;
			end
			// Double first, then add lag again
			tripleLag:
			begin
				opA = tripleStep ? temp : t0Reg;
				opB = t0Reg;
				nextState = tripleStep ? offsetLow : tripleLag;
			end
			offsetLow:
			begin
				opA = lagAcc;
				opB = lowOffset;
				op = opSub;
				nextState = indexLow;
			end
			indexLow:
			begin
				opA = temp;
				opB = t0FracReg;
				nextState = windowLow;
			end
			indexHigh:
			begin
				opA = t0Reg;
				opB = highOffset;
				nextState = windowLow;
			end
			windowLow:
			begin
				opA = t0Reg;
				opB = windowBack;
				op = opSub;
				nextState = clampMin;
			end
			clampMin:
			begin
				opA = t0Min;
				opB = pitMin;
				op = opSub;
				nextState = windowHigh;
			end
			windowHigh:
			begin
				opA = t0Min;
				opB = windowSpan;
				nextState = clampMax;
			end
			// Upper bound past pitMax pulls the window down
			clampMax:
			begin
				opA = t0Max;
				opB = pitMax;
				op = opSub;
				nextState = resultNonPositive ? finish : shiftMin;
			end
			shiftMin:
			begin
				opA = t0Max;
				opB = windowSpan;
				op = opSub;
				nextState = finish;
			end
			finish:
				nextState = idle;
			relLag:
			begin
				opA = t0Reg;
				opB = prevT0Min;
				op = opSub;
				nextState = relDouble;
			end
			relDouble:
			begin
				opA = lagAcc;
				opB = lagAcc;
				nextState = relTriple;
			end
			relTriple:
			begin
				opA = temp;
				opB = lagAcc;
				nextState = relOffset;
			end
			relOffset:
			begin
				opA = lagAcc;
				opB = relBias;
				nextState = relIndex;
			end
			relIndex:
			begin
				opA = temp;
				opB = t0FracReg;
				nextState = finish;
			end
			default:
				nextState = idle;
		endcase
	end

	//////////////////////////////////////////////////
	// State and result registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			t0Reg <= 16'd0;
			t0FracReg <= 16'd0;
			pitFlagReg <= 1'b0;
			lagAcc <= 16'd0;
			temp <= 16'd0;
			tripleStep <= 1'b0;
			index <= 16'd0;
			t0Min <= 16'd0;
			t0Max <= 16'd0;
		end
		else
		begin
			state <= nextState;
			case (state)
				idle:
				begin
					if (start)
					begin
						t0Reg <= t0;
						t0FracReg <= t0Frac;
						pitFlagReg <= pitFlag;
						tripleStep <= 1'b0;
					end
				end
				tripleLag:
				begin
					if (tripleStep)
						lagAcc <= opResult;
					else
						temp <= opResult;
					tripleStep <= !tripleStep;
				end
				offsetLow:
					temp <= opResult;
				indexLow, indexHigh, relIndex:
					index <= opResult;
				windowLow, shiftMin:
					t0Min <= opResult;
				clampMin:
				begin
					if (resultNegative)
						t0Min <= pitMin;
				end
				windowHigh:
					t0Max <= opResult;
				clampMax:
				begin
					if (!resultNonPositive)
						t0Max <= pitMax;
				end
				relLag, relTriple:
					lagAcc <= opResult;
				relDouble, relOffset:
					temp <= opResult;
				default:
				begin
				end
			endcase
		end
	end

endmodule

//--- source/pitchParity.sv
`timescale 1ns/100ps

module pitchParity
(
	input  logic        clk,
	input  logic        reset,
	input  logic        done,
	input  logic        pitFlag,
	input  logic [15:0] index,
	input  logic [15:0] t0MinIn,
	input  logic [15:0] t0MaxIn,
	output logic [15:0] lagIndex,
	output logic [15:0] t0Min,
	output logic [15:0] t0Max,
	output logic        parity,
	output logic        subframeTwo,
	output logic        resultValid
);

	//////////////////////////////////////////////////
	// Result capture
	//////////////////////////////////////////////////

	// Odd parity over index bits 1 to 6
	logic parityNext;

	assign parityNext = 1'b1 ^ (^index[6:1]);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lagIndex <= 16'd0;
			t0Min <= 16'd0;
			t0Max <= 16'd0;
			parity <= 1'b0;
			subframeTwo <= 1'b0;
		end
		else if (done)
		begin
			lagIndex <= index;
			t0Min <= t0MinIn;
			t0Max <= t0MaxIn;
			parity <= parityNext;
			subframeTwo <= pitFlag;
		end
	end

	// Strobe one cycle after done
	always_ff @(posedge clk)
	begin
		if (reset)
			resultValid <= 1'b0;
		else
			resultValid <= done;
	end

endmodule

//--- source/pitchLagCoder.sv
`timescale 1ns/100ps

module pitchLagCoder import lagPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic [15:0] t0,
	input  logic [15:0] t0Frac,
	output logic [15:0] lagIndex,
	output logic        parity,
	output logic [15:0] t0Min,
	output logic [15:0] t0Max,
	output logic        subframeTwo,
	output logic        resultValid
);

	// Control to encoder
	logic        encStart;
	logic        pitFlag;
	logic [15:0] prevT0Min;

	// Encoder to arithmetic unit
	logic [15:0] opA;
	logic [15:0] opB;
	lagOp_t      op;
	logic [15:0] opResult;

	// Encoder results
	logic [15:0] encIndex;
	logic [15:0] encT0Min;
	logic [15:0] encT0Max;
	logic        done;

	//////////////////////////////////////////////////
	// Decode, execute and result stages
	//////////////////////////////////////////////////

	lagFrameControl frameControl0
	(
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.done      (done),
		.t0Min     (encT0Min),
		.encStart  (encStart),
		.pitFlag   (pitFlag),
		.prevT0Min (prevT0Min)
	);

	lagEncoder encoder0
	(
		.clk       (clk),
		.reset     (reset),
		.start     (encStart),
		.pitFlag   (pitFlag),
		.t0        (t0),
		.t0Frac    (t0Frac),
		.prevT0Min (prevT0Min),
		.opResult  (opResult),
		.opA       (opA),
		.opB       (opB),
		.op        (op),
		.index     (encIndex),
		.t0Min     (encT0Min),
		.t0Max     (encT0Max),
		.done      (done)
	);

	// Single shared adder for every encoder step
	saturatingAddSub addSub0
	(
		.a      (opA),
		.b      (opB),
		.op     (op),
		.result (opResult)
	);

	pitchParity parity0
	(
		.clk         (clk),
		.reset       (reset),
		.done        (done),
		.pitFlag     (pitFlag),
		.index       (encIndex),
		.t0MinIn     (encT0Min),
		.t0MaxIn     (encT0Max),
		.lagIndex    (lagIndex),
		.t0Min       (t0Min),
		.t0Max       (t0Max),
		.parity      (parity),
		.subframeTwo (subframeTwo),
		.resultValid (resultValid)
	);

endmodule

//--- sim/lagTestTable.svh
// Each row gives the subframe-one lag and fraction, then the subframe-two lag and fraction
// Subframe-two lags lie inside the window of the subframe-one lag

task automatic loadFixedRows();
	// Low range with the window held at pitMin
	addRow(20, -1, 29, 1);
	addRow(21, 0, 25, -1);
	addRow(24, 1, 22, 1);
	addRow(25, 0, 20, -1);
	// Edges of the fractional range
	addRow(85, 1, 80, -1);
	addRow(85, -1, 89, 1);
	addRow(50, 1, 52, 0);
	// Integer range
	addRow(86, 0, 86, 0);
	addRow(100, 0, 97, -1);
	// Upper clamp
	addRow(143, 0, 134, 0);
	addRow(140, 0, 143, 1);
	// Just below the upper clamp
	addRow(139, 0, 139, -1);
	addRow(138, 0, 142, 1);
endtask

//--- sim/pitchLagCoderTb.sv
`timescale 1ns/100ps

module pitchLagCoderTb import lagPkg::*;
();

	logic        clk;
	logic        reset;
	logic        start;
	logic [15:0] t0;
	logic [15:0] t0Frac;
	logic [15:0] lagIndex;
	logic        parity;
	logic [15:0] t0Min;
	logic [15:0] t0Max;
	logic        subframeTwo;
	logic        resultValid;

	// One subframe pair with its expected results
	typedef struct packed
	{
		logic [15:0] lagOne;
		logic [15:0] fracOne;
		logic [15:0] lagTwo;
		logic [15:0] fracTwo;
		logic [15:0] indexOne;
		logic [15:0] minOne;
		logic [15:0] maxOne;
		logic        parityOne;
		logic [15:0] indexTwo;
		logic        parityTwo;
	} lagRow_t;

	lagRow_t rows[$];
	integer  seed;

	pitchLagCoder dut0
	(
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.t0          (t0),
		.t0Frac      (t0Frac),
		.lagIndex    (lagIndex),
		.parity      (parity),
		.t0Min       (t0Min),
		.t0Max       (t0Max),
		.subframeTwo (subframeTwo),
		.resultValid (resultValid)
	);

	// 20 ns period
	always #10 clk = !clk;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Fractional coding up to 85, integer coding above
	function automatic int modelIndexOne(input int lag, input int frac);
		if (lag <= 85)
			return 3 * lag - 58 + frac;
		return lag + 112;
	endfunction

	// Window start, kept inside the lag range
	function automatic int modelLowerBound(input int lag);
		int low;
		low = lag - 5;
		if (low < int'(pitMin))
			low = int'(pitMin);
		if (low + 9 > int'(pitMax))
			low = int'(pitMax) - 9;
		return low;
	endfunction

	// Relative to the stored window start
	function automatic int modelIndexTwo(input int lag, input int frac, input int low);
		return 3 * (lag - low) + 2 + frac;
	endfunction

	// One plus the ones in bits 1 to 6
	function automatic logic modelParity(input int index);
		int ones;
		ones = 1;
		for (int b = 1; b <= 6; b++)
			ones += (index >> b) & 1;
		return ones[0];
	endfunction

	//////////////////////////////////////////////////
	// Table construction
	//////////////////////////////////////////////////

	task automatic addRow(input int lagOne, input int fracOne, input int lagTwo,
		input int fracTwo);
		lagRow_t row;
		int      low;
		int      indexOne;
		int      indexTwo;
		low = modelLowerBound(lagOne);
		indexOne = modelIndexOne(lagOne, fracOne);
		indexTwo = modelIndexTwo(lagTwo, fracTwo, low);
		row.lagOne = lagOne[15:0];
		row.fracOne = fracOne[15:0];
		row.lagTwo = lagTwo[15:0];
		row.fracTwo = fracTwo[15:0];
		row.indexOne = indexOne[15:0];
		row.minOne = low[15:0];
		// Upper bound always nine above the start
		row.maxOne = 16'(low + 9);
		row.parityOne = modelParity(indexOne);
		row.indexTwo = indexTwo[15:0];
		row.parityTwo = modelParity(indexTwo);
		rows.push_back(row);
	endtask

	function automatic int randomBelow(input int limit);
		logic [31:0] draw;
		draw = $random(seed);
		return int'(draw % limit);
	endfunction

	// Fraction only used in the low range, second lag inside the window
	task automatic addRandomRows(input int count);
		int lagOne;
		int fracOne;
		int lagTwo;
		int fracTwo;
		for (int n = 0; n < count; n++)
		begin
			lagOne = 20 + randomBelow(124);
			fracOne = (lagOne <= 85) ? randomBelow(3) - 1 : 0;
			lagTwo = modelLowerBound(lagOne) + randomBelow(10);
			fracTwo = randomBelow(3) - 1;
			addRow(lagOne, fracOne, lagTwo, fracTwo);
		end
	endtask

	`include "lagTestTable.svh"

	//////////////////////////////////////////////////
	// Checks and bus tasks
	//////////////////////////////////////////////////

	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic checkWord(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
			stopOnError($sformatf("Fail %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stopOnError($sformatf("Fail %s expected %b actual %b", name, expected, actual));
	endtask

	task automatic applyReset();
		@(posedge clk);
		#2;
		reset = 1'b1;
		start = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
	endtask

	// Lag stays on the inputs until the next start
	task automatic applyStart(input logic [15:0] lag, input logic [15:0] frac);
		@(posedge clk);
		#2;
		t0 = lag;
		t0Frac = frac;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
	endtask

	task automatic waitResult();
		@(negedge clk);
		while (!resultValid)
			@(negedge clk);
	endtask

	// Both subframes of one row, optionally with a strobe while busy
	task automatic runPair(input int i, input bit extraStart);
		lagRow_t row;
		row = rows[i];
		applyStart(row.lagOne, row.fracOne);
		if (extraStart)
		begin
			repeat (3) @(posedge clk);
			#2;
			start = 1'b1;
			@(posedge clk);
			#2;
			start = 1'b0;
		end
		waitResult();
		checkWord($sformatf("row %0d first index", i), row.indexOne, lagIndex);
		checkWord($sformatf("row %0d first t0Min", i), row.minOne, t0Min);
		checkWord($sformatf("row %0d first t0Max", i), row.maxOne, t0Max);
		checkBit($sformatf("row %0d first parity", i), row.parityOne, parity);
		checkBit($sformatf("row %0d first subframe", i), 1'b0, subframeTwo);
		if (extraStart)
		begin
			// Ignored strobe must not yield a second result
			repeat (30)
			begin
				@(negedge clk);
				if (resultValid)
					stopOnError("A start issued while busy produced an extra result");
			end
		end
		applyStart(row.lagTwo, row.fracTwo);
		waitResult();
		checkWord($sformatf("row %0d second index", i), row.indexTwo, lagIndex);
		checkWord($sformatf("row %0d second t0Min", i), row.minOne, t0Min);
		checkWord($sformatf("row %0d second t0Max", i), row.maxOne, t0Max);
		checkBit($sformatf("row %0d second parity", i), row.parityTwo, parity);
		checkBit($sformatf("row %0d second subframe", i), 1'b1, subframeTwo);
	endtask

	//////////////////////////////////////////////////
	// Watchdog and main sequence
	//////////////////////////////////////////////////

	// Table runs plus the busy, abort and recovery runs
	initial
	begin
		int watchRuns;
		#1;
		watchRuns = 2 * rows.size() + 8;
		#(watchRuns * 30 * 20);
		stopOnError("Watchdog expired before the last result arrived");
	end

	initial
	begin
		int i;
		seed = 38742;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		t0 = 16'd0;
		t0Frac = 16'd0;
		loadFixedRows();
		addRandomRows(8);
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		checkBit("initial resultValid", 1'b0, resultValid);
		checkBit("initial subframe", 1'b0, subframeTwo);
		checkWord("initial index", 16'd0, lagIndex);
		for (i = 0; i < rows.size(); i++)
			runPair(i, 1'b0);
		runPair(0, 1'b1);
		// Abort a second subframe run
		applyStart(rows[1].lagOne, rows[1].fracOne);
		waitResult();
		applyStart(rows[1].lagTwo, rows[1].fracTwo);
		repeat (2) @(posedge clk);
		applyReset();
		@(negedge clk);
		checkBit("abort resultValid", 1'b0, resultValid);
		checkBit("abort subframe", 1'b0, subframeTwo);
		checkWord("abort index", 16'd0, lagIndex);
		// Back on the first subframe
		runPair(2, 1'b0);
		$display("** PASS **");
		$finish;
	end

endmodule

//--- pitchLagCoder.f
+incdir+sim
source/lagPkg.sv
source/saturatingAddSub.sv
source/lagFrameControl.sv
source/lagEncoder.sv
source/pitchParity.sv
source/pitchLagCoder.sv
sim/pitchLagCoderTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps --top-module pitchLagCoderTb \
	-f pitchLagCoder.f -o simPitchLagCoder &&
./obj_dir/simPitchLagCoder | tee /dev/stderr | grep -qx '\*\* PASS \*\*' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
